//--- verif/graphics_stim.txt
# C op count operand (hex), F capture, E x y (decimal) colour (hex), T test name
# Sprite operands: x hi, x lo, y hi, y lo, width hi, width lo, colours, offset, data
C 14 0 0
F
E 0 0 0
E 63 39 0
T reset_blank_frame
C 11 0 1
C 11 1 f
C 11 2 7
C 11 3 7
C 11 0 2
C 11 1 8
C 11 2 2
C 11 3 5
C 12 0 0
C 12 1 0
C 12 2 0
C 12 3 0
C 12 4 0
C 12 5 2
C 12 6 10
C 12 7 0
C 12 8 21
C 14 0 0
F
E 0 0 3ff
E 1 0 215
E 2 0 0
T palette_sprite_16
C 12 0 0
C 12 1 0
C 12 2 0
C 12 3 2
C 12 4 0
C 12 5 8
C 12 6 2
C 12 7 1
C 12 8 05
C 12 0 0
C 12 1 a
C 12 2 0
C 12 3 2
C 12 4 0
C 12 5 4
C 12 6 4
C 12 7 f
C 12 8 1b
C 14 0 0
F
E 0 2 215
E 1 2 3ff
E 2 2 215
E 7 2 3ff
E 10 2 215
E 11 2 3ff
E 12 2 0
E 0 0 0
T packed_depths_offset
C 12 0 0
C 12 1 3f
C 12 2 0
C 12 3 26
C 12 4 0
C 12 5 2
C 12 6 10
C 12 7 0
C 12 8 21
C 12 9 21
C 12 a 21
F
E 63 38 0
E 0 2 215
C 14 0 0
F
E 63 38 3ff
E 63 39 3ff
E 0 39 0
E 63 0 0
E 0 0 3ff
C 14 0 0
F
E 63 38 0
E 0 2 215
T edge_clip_hidden_swap
C 11 0 1
C 11 1 3
C 11 2 1
C 11 3 6
F
E 1 2 0ce
E 11 2 0ce
E 0 2 215
T palette_reassign

//--- list.f
verilog/graphics_pkg.sv
verilog/sprite_cmd_if.sv
verilog/command_decoder.sv
verilog/sprite_engine.sv
verilog/display_buffers.sv
verilog/color_palette.sv
verilog/display_driver.sv
verilog/graphics.sv
verif/graphics_asserts.sv
verif/graphics_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= graphics_tb
FILE_LIST  ?= list.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= TEST PASS
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/graphics_tb.sv
module graphics_tb;
    import graphics_pkg::*;

    // Two full frames cover any single wait
    localparam int wait_limit = 2 * line_length * frame_lines;

    logic                clock;
    logic                reset;
    logic [7:0]          op_code;
    logic [7:0]          operand;
    logic                operand_valid;
    logic [15:0]         operand_count;
    logic                display_hsync;
    logic                display_vsync;
    logic                display_active;
    logic [y_width-1:0]  display_y;
    logic [cb_width-1:0] display_cb;
    logic [cr_width-1:0] display_cr;

    logic [color_value_width-1:0] frame [screen_height][screen_width];

    int tests_run;
    int tests_failed;
    int total_errors;
    int test_errors;
    bit timed_out;

    graphics UUT (
        .clock          (clock),
        .reset          (reset),
        .op_code        (op_code),
        .operand        (operand),
        .operand_valid  (operand_valid),
        .operand_count  (operand_count),
        .display_hsync  (display_hsync),
        .display_vsync  (display_vsync),
        .display_active (display_active),
        .display_y      (display_y),
        .display_cb     (display_cb),
        .display_cr     (display_cr)
    );

    initial clock = 1'b0;
    always #4 clock = ~clock;

    // Inputs change and outputs are sampled just after the edge
    task automatic next_cycle;
        @(posedge clock);
        #1;
    endtask

    task automatic advance_or_stop(inout int cycles, input string what);
        if (cycles >= wait_limit) begin
            $display("Timed out at time %0t waiting for %0s", $time, what);
            timed_out = 1'b1;
            test_errors++;
        end else begin
            next_cycle;
            cycles++;
        end
    endtask

    function automatic logic sync_level(input bit vertical);
        return vertical ? display_vsync : display_hsync;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("Fail at time %0t: %0s expected %0h, actual %0h",
                     $time, name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic send_operand(input logic [7:0] op, input logic [15:0] count,
                                input logic [7:0] value);
        op_code       = op;
        operand_count = count;
        operand       = value;
        operand_valid = 1'b1;
        next_cycle;
        operand_valid = 1'b0;
        // Long enough for a 2-colour byte to unpack
        repeat (9) next_cycle;
    endtask

    task automatic wait_sync(input bit vertical, input logic level);
        int cycles;
        cycles = 0;
        while (!timed_out && sync_level(vertical) != level) begin
            advance_or_stop(cycles, vertical ? "display_vsync" : "display_hsync");
        end
    endtask

    // Pulse width counted from the rising edge
    task automatic check_sync_span(input bit vertical, input int expected);
        int cycles;
        wait_sync(vertical, 1'b0);
        wait_sync(vertical, 1'b1);
        cycles = 0;
        while (!timed_out && sync_level(vertical)) begin
            advance_or_stop(cycles, "the end of a sync pulse");
        end
        if (!timed_out) begin
            check_value(vertical ? "display_vsync span" : "display_hsync span",
                        expected, cycles);
        end
    endtask

    task automatic capture_frame;
        int cycles;
        int count;
        check_sync_span(1'b0, hsync_end - hsync_start);
        check_sync_span(1'b1, (vsync_end - vsync_start) * line_length);
        cycles = 0;
        count  = 0;
        while (!timed_out && count < frame_pixels) begin
            if (display_active) begin
                frame[count / screen_width][count % screen_width] =
                    {display_y, display_cb, display_cr};
                count++;
            end
            advance_or_stop(cycles, "the active pixels of a frame");
        end
    endtask

    task automatic finish_test(input logic [8*32-1:0] name);
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("Test %0s passed", name);
        end else begin
            tests_failed++;
            $display("Test %0s failed with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        int               fd;
        int               items;
        int               x;
        int               y;
        logic [7:0]       kind;
        logic [7:0]       op;
        logic [15:0]      count;
        logic [15:0]      value;
        logic [8*32-1:0]  name;
        logic [8*128-1:0] rest;

        reset         = 1'b1;
        op_code       = '0;
        operand       = '0;
        operand_valid = 1'b0;
        operand_count = '0;
        tests_run     = 0;
        tests_failed  = 0;
        total_errors  = 0;
        test_errors   = 0;
        timed_out     = 1'b0;
        repeat (5) next_cycle;
        reset = 1'b0;

        fd = $fopen("verif/graphics_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            test_errors++;
        end else begin
            while (!timed_out && $fscanf(fd, "%s", kind) == 1) begin
                case (kind)
                    "#": items = $fgets(rest, fd);
                    "C": begin
                        items = $fscanf(fd, "%h %h %h", op, count, value);
                        if (items == 3) begin
                            send_operand(op, count, value[7:0]);
                        end else begin
                            $display("Command line in the stimulus file is incomplete");
                            test_errors++;
                        end
                    end
                    "F": capture_frame;
                    "E": begin
                        items = $fscanf(fd, "%d %d %h", x, y, value);
                        if (items == 3) begin
                            check_value($sformatf("pixel (%0d,%0d)", x, y),
                                        int'(value), int'(frame[y][x]));
                        end else begin
                            $display("Pixel line in the stimulus file is incomplete");
                            test_errors++;
                        end
                    end
                    "T": begin
                        items = $fscanf(fd, "%s", name);
                        finish_test(name);
                    end
                    default: begin
                        $display("Stimulus line of unknown kind %c", kind);
                        test_errors++;
                    end
                endcase
            end
            $fclose(fd);
        end

        total_errors += test_errors + UUT.display_checks.failures;
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
        if (total_errors == 0 && tests_run > 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- verif/graphics_asserts.sv
module graphics_asserts (
    input logic                                         clock,
    input logic                                         reset,
    input logic                                         display_hsync,
    input logic                                         display_vsync,
    input logic                                         display_active,
    input logic [graphics_pkg::y_width-1:0]             display_y,
    input logic [graphics_pkg::cb_width-1:0]            display_cb,
    input logic [graphics_pkg::cr_width-1:0]            display_cr,
    input logic                                         pixel_write,
    input logic [graphics_pkg::pixel_address_width-1:0] pixel_address
);
    import graphics_pkg::*;

    int failures = 0;

    // Both sync pulses sit in blanking
    sync_in_blanking: assert property (
        @(posedge clock) disable iff (reset)
        display_active |-> !display_hsync && !display_vsync
    ) else begin
        $error("Sync pulse during active video");
        failures++;
    end

    blank_color: assert property (
        @(posedge clock) disable iff (reset)
        !display_active |-> display_y == '0 && display_cb == '0 && display_cr == '0
    ) else begin
        $error("Colour output not blank outside the active area");
        failures++;
    end

    write_in_frame: assert property (
        @(posedge clock) disable iff (reset)
        pixel_write |-> pixel_address < pixel_address_width'(frame_pixels)
    ) else begin
        $error("Pixel write beyond the frame buffer");
        failures++;
    end

endmodule

bind graphics graphics_asserts display_checks (.*);

//--- verilog/graphics.sv
module graphics (
    input  logic                             clock,
    input  logic                             reset,
    input  logic [7:0]                       op_code,
    input  logic [7:0]                       operand,
    input  logic                             operand_valid,
    input  logic [15:0]                      operand_count,
    output logic                             display_hsync,
    output logic                             display_vsync,
    output logic                             display_active,
    output logic [graphics_pkg::y_width-1:0]  display_y,
    output logic [graphics_pkg::cb_width-1:0] display_cb,
    output logic [graphics_pkg::cr_width-1:0] display_cr
);
    import graphics_pkg::*;

    logic                           palette_write;
    logic [color_index_width-1:0]   palette_index;
    logic [color_value_width-1:0]   palette_value;
    logic                           switch_buffer;

    logic                           pixel_write;
    logic [pixel_address_width-1:0] pixel_address;
    logic [color_index_width-1:0]   pixel_index;

    logic [pixel_address_width-1:0] read_address;
    logic [color_index_width-1:0]   read_index;
    logic [color_value_width-1:0]   color_value;

    sprite_cmd_if sprite_cmd ();

    command_decoder command_decoder (
        .clock         (clock),
        .reset         (reset),
        .op_code       (op_code),
        .operand       (operand),
        .operand_valid (operand_valid),
        .operand_count (operand_count),
        .palette_write (palette_write),
        .palette_index (palette_index),
        .palette_value (palette_value),
        .switch_buffer (switch_buffer),
        .sprite        (sprite_cmd.decoder)
    );

    // Only writer into the hidden frame
    sprite_engine sprite_engine (
        .clock         (clock),
        .reset         (reset),
        .sprite        (sprite_cmd.engine),
        .pixel_write   (pixel_write),
        .pixel_address (pixel_address),
        .pixel_index   (pixel_index)
    );

    display_buffers display_buffers (
        .clock         (clock),
        .reset         (reset),
        .pixel_write   (pixel_write),
        .pixel_address (pixel_address),
        .pixel_index   (pixel_index),
        .read_address  (read_address),
        .switch_buffer (switch_buffer),
        .read_index    (read_index)
    );

    color_palette color_palette (
        .clock         (clock),
        .reset         (reset),
        .palette_write (palette_write),
        .palette_index (palette_index),
        .palette_value (palette_value),
        .read_index    (read_index),
        .color_value   (color_value)
    );

    display_driver display_driver (
        .clock          (clock),
        .reset          (reset),
        .color_value    (color_value),
        .read_address   (read_address),
        .display_hsync  (display_hsync),
        .display_vsync  (display_vsync),
        .display_active (display_active),
        .display_y      (display_y),
        .display_cb     (display_cb),
        .display_cr     (display_cr)
    );

endmodule

//--- verilog/display_driver.sv
module display_driver (
    input  logic                                         clock,
    input  logic                                         reset,
    input  logic [graphics_pkg::color_value_width-1:0]   color_value,
    output logic [graphics_pkg::pixel_address_width-1:0] read_address,
    output logic                                         display_hsync,
    output logic                                         display_vsync,
    output logic                                         display_active,
    output logic [graphics_pkg::y_width-1:0]             display_y,
    output logic [graphics_pkg::cb_width-1:0]            display_cb,
    output logic [graphics_pkg::cr_width-1:0]            display_cr
);
    import graphics_pkg::*;

    logic [h_count_width-1:0] column;
    logic [v_count_width-1:0] line;
    logic                     active;
    logic                     hsync;
    logic                     vsync;

    // Two stages to match the buffer read and palette lookup
    logic [1:0] active_delay;
    logic [1:0] hsync_delay;
    logic [1:0] vsync_delay;

    always_ff @(posedge clock) begin
        if (reset) begin
            column <= '0;
            line   <= '0;
        end else if (column == h_count_width'(line_length - 1)) begin
            column <= '0;
            if (line == v_count_width'(frame_lines - 1)) begin
                line <= '0;
            end else begin
                line <= line + 1'b1;
            end
        end else begin
            column <= column + 1'b1;
        end
    end

    always_comb begin
        active = (column < screen_width) && (line < screen_height);
        hsync  = (column >= hsync_start) && (column < hsync_end);
        vsync  = (line >= vsync_start) && (line < vsync_end);
        read_address = active ? pixel_address_width'(line * screen_width + column) : '0;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            active_delay   <= '0;
            hsync_delay    <= '0;
            vsync_delay    <= '0;
            display_active <= 1'b0;
            display_hsync  <= 1'b0;
            display_vsync  <= 1'b0;
            display_y      <= '0;
            display_cb     <= '0;
            display_cr     <= '0;
        end else begin
            active_delay   <= {active_delay[0], active};
            hsync_delay    <= {hsync_delay[0], hsync};
            vsync_delay    <= {vsync_delay[0], vsync};
            display_active <= active_delay[1];
            display_hsync  <= hsync_delay[1];
            display_vsync  <= vsync_delay[1];
            // Blank outside the active area
            if (active_delay[1]) begin
                display_y  <= color_value[color_value_width-1 -: y_width];
                display_cb <= color_value[cb_width+cr_width-1 -: cb_width];
                display_cr <= color_value[cr_width-1:0];
            end else begin
                display_y  <= '0;
                display_cb <= '0;
                display_cr <= '0;
            end
        end
    end

endmodule

//--- verilog/color_palette.sv
module color_palette (
    input  logic                                       clock,
    input  logic                                       reset,
    input  logic                                       palette_write,
    input  logic [graphics_pkg::color_index_width-1:0] palette_index,
    input  logic [graphics_pkg::color_value_width-1:0] palette_value,
    input  logic [graphics_pkg::color_index_width-1:0] read_index,
    output logic [graphics_pkg::color_value_width-1:0] color_value
);
    import graphics_pkg::*;

    logic [color_value_width-1:0] palette [1 << color_index_width];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < (1 << color_index_width); i++) begin
                palette[i] <= '0;
            end
            color_value <= '0;
        end else begin
            if (palette_write) begin
                palette[palette_index] <= palette_value;
            end
            // Same-cycle write is not seen by this lookup
            color_value <= palette[read_index];
        end
    end

endmodule

//--- verilog/display_buffers.sv
module display_buffers (
    input  logic                                         clock,
    input  logic                                         reset,
    input  logic                                         pixel_write,
    input  logic [graphics_pkg::pixel_address_width-1:0] pixel_address,
    input  logic [graphics_pkg::color_index_width-1:0]   pixel_index,
    input  logic [graphics_pkg::pixel_address_width-1:0] read_address,
    input  logic                                         switch_buffer,
    output logic [graphics_pkg::color_index_width-1:0]   read_index
);
    import graphics_pkg::*;

    // Both frames come up blank
    logic [color_index_width-1:0] buffer_0 [frame_pixels] = '{default: '0};
    logic [color_index_width-1:0] buffer_1 [frame_pixels] = '{default: '0};

    // Low shows buffer_0 and draws into buffer_1
    logic buffer_select;

    always_ff @(posedge clock) begin
        if (reset) begin
            buffer_select <= 1'b0;
        end else if (switch_buffer) begin
            buffer_select <= ~buffer_select;
        end
    end

    always_ff @(posedge clock) begin
        if (pixel_write && buffer_select) begin
            buffer_0[pixel_address] <= pixel_index;
        end
    end

    always_ff @(posedge clock) begin
        if (pixel_write && !buffer_select) begin
            buffer_1[pixel_address] <= pixel_index;
        end
    end

    // Registered read of the shown frame
    always_ff @(posedge clock) begin
        read_index <= buffer_select ? buffer_1[read_address] : buffer_0[read_address];
    end

endmodule

//--- verilog/sprite_engine.sv
module sprite_engine (
    input  logic                                         clock,
    input  logic                                         reset,
    sprite_cmd_if.engine                                 sprite,
    output logic                                         pixel_write,
    output logic [graphics_pkg::pixel_address_width-1:0] pixel_address,
    output logic [graphics_pkg::color_index_width-1:0]   pixel_index
);
    import graphics_pkg::*;

    logic [7:0]                   shift_data;
    logic [3:0]                   pixels_left;
    logic [coord_width-1:0]       column;
    logic [coord_width-1:0]       row;
    logic [2:0]                   bits_per_pixel;
    logic [3:0]                   pixels_per_byte;
    logic [color_index_width-1:0] pixel_mask;
    logic [coord_width:0]         screen_x;
    logic [coord_width:0]         screen_y;
    logic                         busy;
    logic                         accept;
    logic                         on_screen;

    // Unpacking depth from the colour count
    always_comb begin
        case (sprite.color_count)
            color_count_width'(2): begin
                bits_per_pixel  = 3'd1;
                pixels_per_byte = 4'd8;
                pixel_mask      = 4'b0001;
            end
            color_count_width'(4): begin
                bits_per_pixel  = 3'd2;
                pixels_per_byte = 4'd4;
                pixel_mask      = 4'b0011;
            end
            default: begin
                bits_per_pixel  = 3'd4;
                pixels_per_byte = 4'd2;
                pixel_mask      = 4'b1111;
            end
        endcase
    end

    always_comb begin
        busy = pixels_left != 4'd0;
        // A new byte may land on the last pixel of the previous one
        accept = sprite.data_valid && (pixels_left <= 4'd1);

        screen_x  = {1'b0, sprite.x_position} + {1'b0, column};
        screen_y  = {1'b0, sprite.y_position} + {1'b0, row};
        on_screen = (screen_x < screen_width) && (screen_y < screen_height);

        pixel_write   = busy && on_screen;
        pixel_address = pixel_address_width'(screen_y * screen_width + screen_x);
        pixel_index   = (shift_data[color_index_width-1:0] & pixel_mask) + sprite.palette_offset;
    end

    // Cursor and byte counter
    always_ff @(posedge clock) begin
        if (reset) begin
            pixels_left <= 4'd0;
            column      <= '0;
            row         <= '0;
        end else begin
            if (sprite.start) begin
                column <= '0;
                row    <= '0;
            end else if (busy) begin
                if (column == sprite.width - 1'b1) begin
                    column <= '0;
                    row    <= row + 1'b1;
                end else begin
                    column <= column + 1'b1;
                end
            end

            if (accept) begin
                pixels_left <= pixels_per_byte;
            end else if (busy) begin
                pixels_left <= pixels_left - 1'b1;
            end
        end
    end

    // Low bits go out first
    always_ff @(posedge clock) begin
        if (accept) begin
            shift_data <= sprite.data;
        end else if (busy) begin
            shift_data <= shift_data >> bits_per_pixel;
        end
    end

endmodule

//--- verilog/command_decoder.sv
module command_decoder (
    input  logic                                       clock,
    input  logic                                       reset,
    input  logic [7:0]                                 op_code,
    input  logic [7:0]                                 operand,
    input  logic                                       operand_valid,
    input  logic [15:0]                                operand_count,
    output logic                                       palette_write,
    output logic [graphics_pkg::color_index_width-1:0] palette_index,
    output logic [graphics_pkg::color_value_width-1:0] palette_value,
    output logic                                       switch_buffer,
    sprite_cmd_if.decoder                              sprite
);
    import graphics_pkg::*;

    logic is_color;
    logic is_sprite;
    logic is_switch;

    always_comb begin
        is_color  = operand_valid && (op_code == op_assign_color);
        is_sprite = operand_valid && (op_code == op_draw_sprite);
        is_switch = operand_valid && (op_code == op_switch_buffer);
    end

    // Strobes one cycle after the operand
    always_ff @(posedge clock) begin
        if (reset) begin
            palette_write     <= 1'b0;
            switch_buffer     <= 1'b0;
            sprite.start      <= 1'b0;
            sprite.data_valid <= 1'b0;
        end else begin
            palette_write     <= is_color && (operand_count == 16'd3);
            switch_buffer     <= is_switch;
            sprite.start      <= is_sprite && (operand_count == 16'(sprite_header_bytes - 1));
            sprite.data_valid <= is_sprite && (operand_count >= 16'(sprite_header_bytes));
        end
    end

    // Palette entry assembly
    always_ff @(posedge clock) begin
        if (is_color) begin
            case (operand_count)
                16'd0: palette_index <= operand[color_index_width-1:0];
                16'd1: palette_value[color_value_width-1 -: y_width] <= operand[y_width-1:0];
                16'd2: palette_value[cb_width+cr_width-1 -: cb_width] <= operand[cb_width-1:0];
                16'd3: palette_value[cr_width-1:0] <= operand[cr_width-1:0];
                default: ;
            endcase
        end
    end

    // Sprite header fields and then data bytes
    always_ff @(posedge clock) begin
        if (is_sprite) begin
            case (operand_count)
                16'd0: sprite.x_position[coord_width-1:8] <= operand[coord_width-9:0];
                16'd1: sprite.x_position[7:0] <= operand;
                16'd2: sprite.y_position[coord_width-1:8] <= operand[coord_width-9:0];
                16'd3: sprite.y_position[7:0] <= operand;
                16'd4: sprite.width[coord_width-1:8] <= operand[coord_width-9:0];
                16'd5: sprite.width[7:0] <= operand;
                // Anything but 2 or 4 colours means 16
                16'd6: begin
                    if (operand == 8'd2 || operand == 8'd4) begin
                        sprite.color_count <= operand[color_count_width-1:0];
                    end else begin
                        sprite.color_count <= color_count_width'(16);
                    end
                end
                16'd7: sprite.palette_offset <= operand[color_index_width-1:0];
                default: sprite.data <= operand;
            endcase
        end
    end

endmodule

//--- verilog/sprite_cmd_if.sv
interface sprite_cmd_if;
    import graphics_pkg::*;

    logic                         start;
    logic [coord_width-1:0]       x_position;
    logic [coord_width-1:0]       y_position;
    logic [coord_width-1:0]       width;
    logic [color_count_width-1:0] color_count;
    logic [color_index_width-1:0] palette_offset;
    logic [7:0]                   data;
    logic                         data_valid;

    modport decoder (
        output start, x_position, y_position, width, color_count, palette_offset,
        output data, data_valid
    );

    modport engine (
        input start, x_position, y_position, width, color_count, palette_offset,
        input data, data_valid
    );

endinterface

//--- verilog/graphics_pkg.sv
package graphics_pkg;

    // Active area kept small so simulation stays short
    localparam int screen_width  = 64;
    localparam int screen_height = 40;
    localparam int frame_pixels  = screen_width * screen_height;

    // Raster timing in clocks per line and lines per frame
    localparam int line_length = 80;
    localparam int frame_lines = 48;
    localparam int hsync_start = 68;
    localparam int hsync_end   = 76;
    localparam int vsync_start = 42;
    localparam int vsync_end   = 44;

    localparam int h_count_width = $clog2(line_length);
    localparam int v_count_width = $clog2(frame_lines);

    // Field widths
    localparam int pixel_address_width = 12;
    localparam int coord_width         = 10;
    localparam int color_index_width   = 4;
    localparam int color_count_width   = 5;

    // Colour packing is Y, then Cb, then Cr
    localparam int y_width           = 4;
    localparam int cb_width          = 3;
    localparam int cr_width          = 3;
    localparam int color_value_width = y_width + cb_width + cr_width;

    // Op codes
    localparam logic [7:0] op_assign_color  = 8'h11;
    localparam logic [7:0] op_draw_sprite   = 8'h12;
    localparam logic [7:0] op_switch_buffer = 8'h14;

    // Operands before sprite pixel data starts
    localparam int sprite_header_bytes = 8;

endpackage
